//--- Makefile
# Verilator build and run of the IO bridge testbench
# Any of these can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_st_io_bridge
FILELIST  ?= st_io_bridge.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?=

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

# Builds the simulation executable
compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# A failing run exits nonzero, so make fails too
run: compile
	./$(SIM) $(RUN_ARGS)

clean:
	rm -rf $(OBJ_DIR)

//--- host_port_arbiter.sv
//****************************************
// Round robin onto one host bus, one credit per byte
// Host must not return more than it was given
//****************************************
`timescale 1ns/1ps

`include "st_io_settings.svh"

module host_port_arbiter (
	input  logic              clk_96,
	input  logic              reset,
	io_queue_if.reader        midi_q,
	io_queue_if.reader        printer_q,
	input  logic              host_credit,  // One cycle, gives back one credit
	output logic              host_valid,
	output st_io_pkg::chan_t  host_channel,
	output st_io_pkg::byte_t  host_byte
);

	localparam int CRED_W = $clog2(`HOST_CREDITS + 1);

	logic [CRED_W-1:0] credits;       // Credits still usable by us
	st_io_pkg::chan_t  last_grant;    // Channel served most recently
	logic              have_credit;
	logic              pick_printer;  // Channel chosen this cycle
	logic              grant;         // A byte moves at this edge

	assign have_credit = (credits != '0);

	// Alternate when both wait, otherwise take whichever has data
	always_comb begin
		if (midi_q.available & printer_q.available)
			pick_printer = (last_grant == st_io_pkg::CHAN_MIDI);
		else
			pick_printer = printer_q.available;
	end

	assign grant = have_credit & (midi_q.available | printer_q.available);

	// Pops go straight to the queues, same edge as host_valid
	assign midi_q.pop    = grant & ~pick_printer;
	assign printer_q.pop = grant & pick_printer;

	always_ff @(posedge clk_96) begin
		if (reset) begin
			credits    <= CRED_W'(`HOST_CREDITS);
			last_grant <= st_io_pkg::CHAN_PRINTER; // First tie goes to MIDI
			host_valid <= 1'b0;
		end else begin
			host_valid <= grant; // High for exactly one cycle per byte
			case ({grant, host_credit})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits; // Spent and returned together
			endcase
			if (grant)
				last_grant <= pick_printer ? st_io_pkg::CHAN_PRINTER
				                           : st_io_pkg::CHAN_MIDI;
		end
	end

	// Payload only meaningful with host_valid
	always_ff @(posedge clk_96) begin
		if (grant) begin
			host_channel <= pick_printer ? st_io_pkg::CHAN_PRINTER
			                             : st_io_pkg::CHAN_MIDI;
			host_byte    <= pick_printer ? printer_q.data : midi_q.data;
		end
	end

	// Host side protocol, no return while we already hold them all
	credit_no_overflow: assert property (
		@(posedge clk_96) disable iff (reset)
		host_credit |-> (credits < CRED_W'(`HOST_CREDITS))
	) else $error("credit returned above limit");

	// Every byte on the bus was paid for in the cycle it left
	valid_needs_credit: assert property (
		@(posedge clk_96) disable iff (reset)
		host_valid |-> ($past(credits) != '0)
	) else $error("host_valid without credit");

endmodule

//--- io_byte_queue.sv
//****************************************
// Byte queue that drops writes while full
// Overflow is sticky until reset
//****************************************
`timescale 1ns/1ps

module io_byte_queue #(
	parameter int DEPTH = 4
) (
	input  logic             clk_96,
	input  logic             reset,
	input  logic             write,    // One cycle strobe from producer
	input  st_io_pkg::byte_t wdata,
	output logic             overflow, // Sticky flag for a lost write
	io_queue_if.queue        q
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	st_io_pkg::byte_t mem [DEPTH]; // Circular storage
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr;
	logic [CNT_W-1:0] count;       // Occupancy
	logic             push;        // Write actually accepted

	// Advance with wrap for any depth
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign q.full      = (count == CNT_W'(DEPTH));
	assign q.available = (count != '0);
	assign q.data      = mem[rd_ptr]; // Head entry after the write edge

	// Full queue still takes a write when the head leaves at the same edge
	assign push = write & (~q.full | q.pop);

	always_ff @(posedge clk_96) begin
		if (reset) begin
			rd_ptr   <= '0;
			wr_ptr   <= '0;
			count    <= '0;
			overflow <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (q.pop)
				rd_ptr <= next_ptr(rd_ptr);
			case ({push, q.pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // Both or neither
			endcase
			if (write & ~push)
				overflow <= 1'b1; // Byte dropped
		end
	end

	// Entry write on an accepted push
	always_ff @(posedge clk_96) begin
		if (push)
			mem[wr_ptr] <= wdata;
	end

	// Arbiter must never pop an empty queue
	pop_needs_data: assert property (
		@(posedge clk_96) disable iff (reset)
		q.pop |-> q.available
	) else $error("pop while queue empty");

	// Occupancy stays in range across any write and pop mix
	count_in_range: assert property (
		@(posedge clk_96) disable iff (reset)
		count <= CNT_W'(DEPTH)
	) else $error("queue count above depth");

endmodule

//--- io_queue_if.sv
//****************************************
// Queue to arbiter link, pop only when available
//****************************************
`timescale 1ns/1ps

interface io_queue_if;

	st_io_pkg::byte_t data; // Head entry, valid with available
	logic available;        // Queue holds at least one byte
	logic full;             // No room for another write
	logic pop;              // Drop head entry at this edge

	// Owned by the queue
	modport queue (
		output data,
		output available,
		output full,
		input  pop
	);

	// Owned by the host port arbiter
	modport reader (
		input  data,
		input  available,
		input  full,
		output pop
	);

endinterface

//--- printer_status.sv
//****************************************
// Printer busy source select, output registered
//****************************************
`timescale 1ns/1ps

`include "st_io_settings.svh"

module printer_status (
	input  logic                 clk_96,
	input  logic                 reset,
	input  st_io_pkg::redirect_t usb_redirection,
	input  logic                 joy_busy,      // Async, from joystick adapter
	input  logic                 printer_full,  // Printer queue cannot take more
	output logic                 printer_busy
);

	localparam int SYNC_MSB = `SYNC_STAGES - 1;

	logic [SYNC_MSB:0] joy_sync; // Shift chain, bit 0 samples the pin
	logic              joy_busy_s;

	assign joy_busy_s = joy_sync[SYNC_MSB];

	always_ff @(posedge clk_96) begin
		if (reset) begin
			joy_sync     <= '0;
			printer_busy <= 1'b0;
		end else begin
			joy_sync <= (joy_sync << 1) | `SYNC_STAGES'(joy_busy);
			// Queue full only counts when USB serves the printer
			if (usb_redirection == st_io_pkg::REDIR_PRINTER)
				printer_busy <= printer_full;
			else
				printer_busy <= joy_busy_s; // Adapter fire line
		end
	end

endmodule

//--- st_io_bridge.f
+incdir+.
st_io_pkg.sv
io_queue_if.sv
io_byte_queue.sv
host_port_arbiter.sv
printer_status.sv
st_io_bridge.sv
tb_st_io_bridge.sv

//--- st_io_bridge.sv
//****************************************
// MIDI and printer byte channels to the IO controller
// Single clock, host bus is credit based
//****************************************
`timescale 1ns/1ps

`include "st_io_settings.svh"

module st_io_bridge (
	input  logic             clk_96,
	input  logic             reset,
	input  logic [1:0]       usb_redirection,  // 0 none, 1 rs232, 2 printer, 3 midi
	// ACIA data register writes
	input  logic             midi_write,
	input  st_io_pkg::byte_t midi_byte,
	// PSG parallel port writes
	input  logic             parallel_write,
	input  st_io_pkg::byte_t parallel_byte,
	// Extra joystick adapter busy line
	input  logic             joy_busy,
	output logic             printer_busy,
	// Sticky drop flags
	output logic             midi_overflow,
	output logic             parallel_overflow,
	// Host read bus
	input  logic             host_credit,
	output logic             host_valid,
	output st_io_pkg::chan_t host_channel,
	output st_io_pkg::byte_t host_byte
);

	io_queue_if midi_if ();
	io_queue_if printer_if ();

	// Filled by the CPU via the ACIA
	io_byte_queue #(
		.DEPTH ( `MIDI_QUEUE_DEPTH )
	) midi_queue (
		.clk_96   ( clk_96        ),
		.reset    ( reset         ),
		.write    ( midi_write    ),
		.wdata    ( midi_byte     ),
		.overflow ( midi_overflow ),
		.q        ( midi_if       )
	);

	// Small queue, its full flag doubles as printer busy
	io_byte_queue #(
		.DEPTH ( `PRINTER_QUEUE_DEPTH )
	) printer_queue (
		.clk_96   ( clk_96            ),
		.reset    ( reset             ),
		.write    ( parallel_write    ),
		.wdata    ( parallel_byte     ),
		.overflow ( parallel_overflow ),
		.q        ( printer_if        )
	);

	host_port_arbiter host_port_arbiter_i (
		.clk_96       ( clk_96       ),
		.reset        ( reset        ),
		.midi_q       ( midi_if      ),
		.printer_q    ( printer_if   ),
		.host_credit  ( host_credit  ),
		.host_valid   ( host_valid   ),
		.host_channel ( host_channel ),
		.host_byte    ( host_byte    )
	);

	printer_status printer_status_i (
		.clk_96          ( clk_96                                    ),
		.reset           ( reset                                     ),
		.usb_redirection ( st_io_pkg::redirect_t'(usb_redirection)   ),
		.joy_busy        ( joy_busy                                  ),
		.printer_full    ( printer_if.full                           ),
		.printer_busy    ( printer_busy                              )
	);

endmodule

//--- st_io_pkg.sv
//****************************************
// Types for the IO bridge byte channels
//****************************************
package st_io_pkg;

	// One payload byte on any channel
	typedef logic [7:0] byte_t;

	// Channel tag on the host bus
	typedef enum logic {
		CHAN_MIDI    = 1'b0,
		CHAN_PRINTER = 1'b1
	} chan_t;

	// USB target on the IO controller
	typedef enum logic [1:0] {
		REDIR_NONE    = 2'd0,
		REDIR_RS232   = 2'd1,
		REDIR_PRINTER = 2'd2, // Printer busy then comes from queue full
		REDIR_MIDI    = 2'd3
	} redirect_t;

endpackage

//--- st_io_settings.svh
//****************************************
// Depths and counts shared by the IO bridge
// Queue depths must be at least 1
//****************************************
`ifndef ST_IO_SETTINGS_SVH
`define ST_IO_SETTINGS_SVH

// MIDI out queue, filled by ACIA data writes
`define MIDI_QUEUE_DEPTH 16

// Printer queue, filled from the PSG parallel port
`define PRINTER_QUEUE_DEPTH 4

// Credits held by the host after reset, also the ceiling
`define HOST_CREDITS 4

// Flops in the joystick busy synchronizer
`define SYNC_STAGES 2

`endif

//--- tb_st_io_bridge.sv
//****************************************
// Random traffic on both channels, checked every cycle against a model
// Seed is fixed, run length comes from the phase lengths
//****************************************
`timescale 1ns/1ps

`include "st_io_settings.svh"

module tb_st_io_bridge;

	localparam int RESET_CYCLES  = 3;
	localparam int RANDOM_CYCLES = 2000; // Mixed traffic
	localparam int STARVE_CYCLES = 40;   // Credits withheld
	localparam int BURST_CYCLES  = 30;   // Writes every cycle, no credits
	localparam int DRAIN_CYCLES  = 200;
	localparam int TOTAL_CYCLES  = RESET_CYCLES + RANDOM_CYCLES + STARVE_CYCLES
	                               + BURST_CYCLES + DRAIN_CYCLES;

	logic             clk_96 = 1'b0;
	logic             reset;
	logic [1:0]       usb_redirection;
	logic             midi_write;
	st_io_pkg::byte_t midi_byte;
	logic             parallel_write;
	st_io_pkg::byte_t parallel_byte;
	logic             joy_busy;
	logic             printer_busy;
	logic             midi_overflow;
	logic             parallel_overflow;
	logic             host_credit;
	logic             host_valid;
	st_io_pkg::chan_t host_channel;
	st_io_pkg::byte_t host_byte;

	int seed = 85;

	// Model state, always matches the DUT right after the latest edge
	st_io_pkg::byte_t midi_model[$];
	st_io_pkg::byte_t printer_model[$];
	logic             midi_ovf_model;
	logic             printer_ovf_model;
	int               credits_model;    // Arbiter side credit count
	st_io_pkg::chan_t last_grant_model;
	logic             valid_model;
	st_io_pkg::chan_t chan_model;
	st_io_pkg::byte_t byte_model;
	logic             busy_model;
	logic             joy_hist[$];      // joy_busy at the last SYNC_STAGES edges
	int               host_owed;        // Bytes seen minus credits handed back

	st_io_bridge st_io_bridge_i (
		.clk_96            ( clk_96            ),
		.reset             ( reset             ),
		.usb_redirection   ( usb_redirection   ),
		.midi_write        ( midi_write        ),
		.midi_byte         ( midi_byte         ),
		.parallel_write    ( parallel_write    ),
		.parallel_byte     ( parallel_byte     ),
		.joy_busy          ( joy_busy          ),
		.printer_busy      ( printer_busy      ),
		.midi_overflow     ( midi_overflow     ),
		.parallel_overflow ( parallel_overflow ),
		.host_credit       ( host_credit       ),
		.host_valid        ( host_valid        ),
		.host_channel      ( host_channel      ),
		.host_byte         ( host_byte         )
	);

	always #5 clk_96 = ~clk_96; // 10 ns period

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("SOME TESTS FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_byte(input string name, input st_io_pkg::byte_t exp,
	                          input st_io_pkg::byte_t act);
		if (act !== exp)
			stop_on_error($sformatf("ERROR at %0t: %s expected %h actual %h",
			                        $time, name, exp, act));
	endtask

	task automatic check_channel(input string name, input st_io_pkg::chan_t exp,
	                             input st_io_pkg::chan_t act);
		if (act !== exp)
			stop_on_error($sformatf("ERROR at %0t: %s expected %0d actual %0d",
			                        $time, name, exp, act));
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp)
			stop_on_error($sformatf("ERROR at %0t: %s expected %b actual %b",
			                        $time, name, exp, act));
	endtask

	// True with the given percent chance
	function automatic bit chance(input int pct);
		int r;
		r = $random(seed);
		return ((r % 100 + 100) % 100) < pct;
	endfunction

	task automatic reset_model();
		midi_model.delete();
		printer_model.delete();
		joy_hist.delete();
		repeat (`SYNC_STAGES) joy_hist.push_back(1'b0); // Synchronizer cleared
		midi_ovf_model    = 1'b0;
		printer_ovf_model = 1'b0;
		credits_model     = `HOST_CREDITS;
		last_grant_model  = st_io_pkg::CHAN_PRINTER; // First tie goes to MIDI
		valid_model       = 1'b0;
		chan_model        = st_io_pkg::CHAN_MIDI;
		byte_model        = '0;
		busy_model        = 1'b0;
		host_owed         = 0;
	endtask

	// Apply the coming clock edge to the model, inputs are stable here
	task automatic step_model();
		logic midi_avail;
		logic printer_avail;
		logic midi_full;
		logic printer_full;
		logic grant;
		logic take_printer;
		midi_avail    = midi_model.size() != 0;
		printer_avail = printer_model.size() != 0;
		midi_full     = midi_model.size() == `MIDI_QUEUE_DEPTH;
		printer_full  = printer_model.size() == `PRINTER_QUEUE_DEPTH;
		grant         = (credits_model > 0) && (midi_avail || printer_avail);
		if (midi_avail && printer_avail)
			take_printer = (last_grant_model == st_io_pkg::CHAN_MIDI); // Alternate
		else
			take_printer = printer_avail;
		// Busy registers the full state from before this edge
		if (usb_redirection == st_io_pkg::REDIR_PRINTER)
			busy_model = printer_full;
		else
			busy_model = joy_hist[0];
		joy_hist.push_back(joy_busy);
		void'(joy_hist.pop_front());
		valid_model = grant;
		if (grant) begin
			if (take_printer) begin
				chan_model = st_io_pkg::CHAN_PRINTER;
				byte_model = printer_model.pop_front();
			end else begin
				chan_model = st_io_pkg::CHAN_MIDI;
				byte_model = midi_model.pop_front();
			end
			last_grant_model = chan_model;
		end
		credits_model = credits_model - (grant ? 1 : 0) + (host_credit ? 1 : 0);
		// A full queue still takes a byte when its head leaves at this edge
		if (midi_write) begin
			if (!midi_full || (grant && !take_printer))
				midi_model.push_back(midi_byte);
			else
				midi_ovf_model = 1'b1;
		end
		if (parallel_write) begin
			if (!printer_full || (grant && take_printer))
				printer_model.push_back(parallel_byte);
			else
				printer_ovf_model = 1'b1;
		end
	endtask

	// One cycle of stimulus, all percentages
	task automatic drive_traffic(input int midi_pct, input int printer_pct,
	                             input int credit_pct, input int redirect_pct);
		midi_write     <= chance(midi_pct);
		midi_byte      <= st_io_pkg::byte_t'($random(seed));
		parallel_write <= chance(printer_pct);
		parallel_byte  <= st_io_pkg::byte_t'($random(seed));
		host_credit    <= (host_owed > 0) && chance(credit_pct); // Never above the limit
		if (chance(redirect_pct))
			usb_redirection <= 2'($random(seed));
		if (chance(10))
			joy_busy <= ~joy_busy;
	endtask

	// Outputs checked mid cycle where they are stable
	initial begin
		@(negedge reset);
		forever begin
			@(negedge clk_96);
			check_flag("host_valid", valid_model, host_valid);
			if (valid_model) begin
				check_channel("host_channel", chan_model, host_channel);
				check_byte("host_byte", byte_model, host_byte);
			end
			check_flag("midi_overflow", midi_ovf_model, midi_overflow);
			check_flag("parallel_overflow", printer_ovf_model, parallel_overflow);
			check_flag("printer_busy", busy_model, printer_busy);
			if (host_valid)
				host_owed++;
			if (host_credit)
				host_owed--; // Taken at the coming edge
			if (host_owed > `HOST_CREDITS)
				stop_on_error("More bytes reached the host than it had credits for");
			step_model();
		end
	end

	initial begin
		#((TOTAL_CYCLES + 200) * 10);
		$display("Watchdog expired before the stimulus finished");
		$display("SOME TESTS FAILED");
		$fatal(1, "timeout");
	end

	initial begin
		reset           = 1'b1;
		usb_redirection = 2'd0;
		midi_write      = 1'b0;
		midi_byte       = '0;
		parallel_write  = 1'b0;
		parallel_byte   = '0;
		joy_busy        = 1'b0;
		host_credit     = 1'b0;
		reset_model();
		repeat (RESET_CYCLES) @(posedge clk_96);
		reset <= 1'b0;
		repeat (RANDOM_CYCLES) begin
			@(posedge clk_96);
			drive_traffic(20, 10, 50, 2);
		end
		// Host keeps its credits, a few MIDI bytes use up the rest
		repeat (8) begin
			@(posedge clk_96);
			drive_traffic(100, 0, 0, 2);
		end
		repeat (STARVE_CYCLES - 8) begin
			@(posedge clk_96);
			drive_traffic(0, 0, 0, 2);
		end
		if (host_owed != `HOST_CREDITS)
			stop_on_error("Credits were not used up before the burst");
		@(posedge clk_96);
		usb_redirection <= st_io_pkg::REDIR_PRINTER; // Busy from queue full
		drive_traffic(100, 100, 0, 0);
		repeat (BURST_CYCLES - 1) begin
			@(posedge clk_96);
			drive_traffic(100, 100, 0, 0);
		end
		repeat (DRAIN_CYCLES) begin
			@(posedge clk_96);
			drive_traffic(0, 0, 50, 2);
		end
		if (midi_model.size() == 0 && printer_model.size() == 0
		    && midi_ovf_model && printer_ovf_model) begin
			$display("ALL TESTS PASSED");
			$finish;
		end else begin
			$display("Queues did not drain or the burst did not overflow both queues");
			$display("SOME TESTS FAILED");
			$fatal(1, "end of run check");
		end
	end

endmodule
